/* verilog/isa_pkg.sv */
package isa_pkg;

    // Datapath width
    localparam int xlen = 32;

    // Field widths
    localparam int reg_idx_w = 5;
    localparam int opcode_w  = 7;
    localparam int funct3_w  = 3;
    localparam int funct7_w  = 7;

    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [funct3_w-1:0]  funct3_t;
    typedef logic [funct7_w-1:0]  funct7_t;

    // RV32I major opcodes
    typedef enum logic [opcode_w-1:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_e;

    // Instruction class, no_wb covers branches, stores and illegal opcodes
    typedef enum logic [2:0] {
        itype_r     = 3'd0,
        itype_i     = 3'd1,
        itype_s     = 3'd2,
        itype_b     = 3'd3,
        itype_u     = 3'd4,
        itype_j     = 3'd5,
        itype_no_wb = 3'd6
    } instr_type_e;

    // ALU operation selector handed to EX
    typedef enum logic [2:0] {
        alu_add      = 3'd0,
        alu_sub_cmp  = 3'd1,
        alu_r_funct  = 3'd2,
        alu_i_funct  = 3'd3,
        alu_pass_imm = 3'd4,
        alu_pc_add   = 3'd5
    } alu_op_e;

    // Everything the decoder pulls out of one instruction word
    typedef struct packed {
        opcode_e          opcode;
        funct3_t          funct3;
        funct7_t          funct7;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        reg_idx_t         rd;
        logic [xlen-1:0]  imm;
        instr_type_e      instr_type;
        logic             uses_rs1;
        logic             uses_rs2;
    } decoded_t;

endpackage

/* verilog/pipe_pkg.sv */
package pipe_pkg;

    // ROB tag and exception vector widths
    localparam int rob_tag_w = 4;
    localparam int exc_vec_w = 3;

    typedef logic [rob_tag_w-1:0] rob_tag_t;
    typedef logic [exc_vec_w-1:0] exc_vec_t;

    // EX/MEM/WB control bundle
    typedef struct packed {
        logic              alu_src;
        isa_pkg::alu_op_e  alu_op;
        logic              mem_write;
        logic              mem_read;
        logic              branch_inst;
        logic              mem_to_reg;
        logic              reg_write;
    } ctrl_t;

    // Register write from the writeback stage
    typedef struct packed {
        logic                      write_enable;
        isa_pkg::reg_idx_t         write_reg;
        logic [isa_pkg::xlen-1:0]  write_data;
    } wb_port_t;

    // ID/EX pipeline register contents
    typedef struct packed {
        logic                      valid;
        ctrl_t                     ctrl;
        logic [isa_pkg::xlen-1:0]  pc;
        logic [isa_pkg::xlen-1:0]  instruction;
        logic [isa_pkg::xlen-1:0]  data_a;
        logic [isa_pkg::xlen-1:0]  data_b;
        logic [isa_pkg::xlen-1:0]  imm;
        isa_pkg::reg_idx_t         rd;
        // Source numbers for the forwarding unit
        isa_pkg::reg_idx_t         rs1;
        isa_pkg::reg_idx_t         rs2;
        isa_pkg::funct3_t          funct3;
        isa_pkg::funct7_t          funct7;
        rob_tag_t                  rob_tag;
        logic                      allocate;
        exc_vec_t                  exception_vector;
    } idex_t;

endpackage

/* verilog/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
    input  logic [31:0]       instruction,
    output isa_pkg::decoded_t fields
);

    logic [isa_pkg::xlen-1:0] imm_i;
    logic [isa_pkg::xlen-1:0] imm_s;
    logic [isa_pkg::xlen-1:0] imm_b;
    logic [isa_pkg::xlen-1:0] imm_u;
    logic [isa_pkg::xlen-1:0] imm_j;

    // Sign-extended immediates for every format
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        // Raw fields sit at fixed positions in every format
        fields.opcode     = isa_pkg::opcode_e'(instruction[6:0]);
        fields.rd         = instruction[11:7];
        fields.funct3     = instruction[14:12];
        fields.rs1        = instruction[19:15];
        fields.rs2        = instruction[24:20];
        fields.funct7     = instruction[31:25];
        fields.imm        = '0;
        fields.instr_type = isa_pkg::itype_no_wb;
        fields.uses_rs1   = 1'b0;
        fields.uses_rs2   = 1'b0;

        case (fields.opcode)
            isa_pkg::opc_lui, isa_pkg::opc_auipc: begin
                fields.imm        = imm_u;
                fields.instr_type = isa_pkg::itype_u;
            end
            isa_pkg::opc_jal: begin
                fields.imm        = imm_j;
                fields.instr_type = isa_pkg::itype_j;
            end
            isa_pkg::opc_jalr, isa_pkg::opc_load, isa_pkg::opc_op_imm: begin
                fields.imm        = imm_i;
                fields.instr_type = isa_pkg::itype_i;
                fields.uses_rs1   = 1'b1;
            end
            // Stores and branches read both sources but write nothing back
            isa_pkg::opc_store: begin
                fields.imm      = imm_s;
                fields.uses_rs1 = 1'b1;
                fields.uses_rs2 = 1'b1;
            end
            isa_pkg::opc_branch: begin
                fields.imm      = imm_b;
                fields.uses_rs1 = 1'b1;
                fields.uses_rs2 = 1'b1;
            end
            isa_pkg::opc_op: begin
                fields.instr_type = isa_pkg::itype_r;
                fields.uses_rs1   = 1'b1;
                fields.uses_rs2   = 1'b1;
            end
            default: begin
                // Illegal opcode keeps the no_wb defaults
                fields.imm = '0;
            end
        endcase
    end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic                      clk,
    input  logic                      arst_n,
    input  pipe_pkg::wb_port_t        wb,
    input  isa_pkg::reg_idx_t         reg_a,
    input  isa_pkg::reg_idx_t         reg_b,
    output logic [isa_pkg::xlen-1:0]  data_a,
    output logic [isa_pkg::xlen-1:0]  data_b
);

    // x0 has no storage
    logic [isa_pkg::xlen-1:0] regs [1:31];

    function automatic logic [isa_pkg::xlen-1:0] read_port(input isa_pkg::reg_idx_t idx);
        logic [isa_pkg::xlen-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (wb.write_enable && wb.write_reg == idx) begin
            // Bypass the write that lands at the coming edge
            value = wb.write_data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.write_enable && wb.write_reg != '0) begin
            regs[wb.write_reg] <= wb.write_data;
        end
    end

    always_comb begin
        data_a = read_port(reg_a);
        data_b = read_port(reg_b);
    end

    x0_reads_zero_a: assert property (@(posedge clk) disable iff (!arst_n)
        (reg_a == '0) |-> (data_a == '0))
        else $error("register_file: x0 read on port a returned a nonzero value");

    x0_reads_zero_b: assert property (@(posedge clk) disable iff (!arst_n)
        (reg_b == '0) |-> (data_b == '0))
        else $error("register_file: x0 read on port b returned a nonzero value");

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ns

module control_unit (
    input  isa_pkg::decoded_t fields,
    output pipe_pkg::ctrl_t   ctrl
);

    always_comb begin
        // Illegal opcodes fall through with everything low
        ctrl = '0;

        case (fields.opcode)
            isa_pkg::opc_load: begin
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = isa_pkg::alu_add;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            isa_pkg::opc_store: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = isa_pkg::alu_add;
                ctrl.mem_write = 1'b1;
            end
            isa_pkg::opc_branch: begin
                ctrl.alu_op      = isa_pkg::alu_sub_cmp;
                ctrl.branch_inst = 1'b1;
            end
            isa_pkg::opc_op: begin
                ctrl.alu_op    = isa_pkg::alu_r_funct;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::opc_op_imm: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = isa_pkg::alu_i_funct;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::opc_lui: begin
                ctrl.alu_op    = isa_pkg::alu_pass_imm;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::opc_auipc, isa_pkg::opc_jal: begin
                ctrl.alu_op    = isa_pkg::alu_pc_add;
                ctrl.reg_write = 1'b1;
            end
            // Target is rs1 plus offset, so a plain add
            isa_pkg::opc_jalr: begin
                ctrl.alu_op    = isa_pkg::alu_add;
                ctrl.reg_write = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* verilog/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
    input  logic               in_valid,
    input  isa_pkg::decoded_t  fields,
    input  isa_pkg::reg_idx_t  idex_rd,
    input  logic               idex_mem_read,
    output logic               stall,
    output logic               pc_write_disable,
    output logic               ifid_write_disable
);

    logic rs1_match;
    logic rs2_match;

    // Only sources the format really reads can conflict
    assign rs1_match = fields.uses_rs1 && (fields.rs1 == idex_rd);
    assign rs2_match = fields.uses_rs2 && (fields.rs2 == idex_rd);

    // Load in EX whose result the incoming instruction needs
    assign stall = in_valid && idex_mem_read && (idex_rd != '0) && (rs1_match || rs2_match);

    // Fetch holds PC and IF/ID together
    assign pc_write_disable   = stall;
    assign ifid_write_disable = stall;

    always_comb begin
        stall_freezes_fetch: assert (!stall || (pc_write_disable && ifid_write_disable))
            else $error("hazard_unit: stall without both fetch disables");
    end

endmodule

/* verilog/stage_decode.sv */
`timescale 1ns/1ns

module stage_decode (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  logic [isa_pkg::xlen-1:0]  instruction,
    input  logic [isa_pkg::xlen-1:0]  pc,
    input  pipe_pkg::rob_tag_t        rob_tag,
    input  pipe_pkg::exc_vec_t        exception_vector,
    input  pipe_pkg::wb_port_t        wb,
    input  isa_pkg::reg_idx_t         idex_rd,
    input  logic                      idex_mem_read,
    output pipe_pkg::idex_t           next_idex,
    output logic                      pc_write_disable,
    output logic                      ifid_write_disable
);

    isa_pkg::decoded_t         fields;
    pipe_pkg::ctrl_t           ctrl_raw;
    logic [isa_pkg::xlen-1:0]  data_a;
    logic [isa_pkg::xlen-1:0]  data_b;
    logic                      stall;
    logic                      issue;
    logic                      writes_back;

    instr_decoder u_decoder (
        .instruction (instruction),
        .fields      (fields)
    );

    register_file u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .wb     (wb),
        .reg_a  (fields.rs1),
        .reg_b  (fields.rs2),
        .data_a (data_a),
        .data_b (data_b)
    );

    control_unit u_control (
        .fields (fields),
        .ctrl   (ctrl_raw)
    );

    hazard_unit u_hazard (
        .in_valid           (in_valid),
        .fields             (fields),
        .idex_rd            (idex_rd),
        .idex_mem_read      (idex_mem_read),
        .stall              (stall),
        .pc_write_disable   (pc_write_disable),
        .ifid_write_disable (ifid_write_disable)
    );

    // Instruction actually moves into EX this cycle
    assign issue = in_valid && !stall;

    // Stores take a ROB slot too since the store buffer lives there
    assign writes_back = (fields.instr_type != isa_pkg::itype_no_wb) ||
                         (fields.opcode == isa_pkg::opc_store);

    always_comb begin
        next_idex.valid            = issue;
        // Bubble carries no control so nothing downstream acts on it
        next_idex.ctrl             = issue ? ctrl_raw : '0;
        next_idex.pc               = pc;
        next_idex.instruction      = instruction;
        next_idex.data_a           = data_a;
        next_idex.data_b           = data_b;
        next_idex.imm              = fields.imm;
        next_idex.rd               = fields.rd;
        next_idex.rs1              = fields.rs1;
        next_idex.rs2              = fields.rs2;
        next_idex.funct3           = fields.funct3;
        next_idex.funct7           = fields.funct7;
        next_idex.rob_tag          = rob_tag;
        next_idex.allocate         = issue && writes_back;
        next_idex.exception_vector = exception_vector;
    end

endmodule

/* verilog/decode_top.sv */
`timescale 1ns/1ns

module decode_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  logic [isa_pkg::xlen-1:0]  instruction,
    input  logic [isa_pkg::xlen-1:0]  pc,
    input  pipe_pkg::rob_tag_t        rob_tag,
    input  pipe_pkg::exc_vec_t        exception_vector,
    input  pipe_pkg::wb_port_t        wb,
    input  logic                      flush,
    output pipe_pkg::idex_t           idex,
    output logic                      pc_write_disable,
    output logic                      ifid_write_disable
);

    pipe_pkg::idex_t next_idex;

    // Load-use loop closes through the registered rd and mem_read
    stage_decode u_stage (
        .clk                (clk),
        .arst_n             (arst_n),
        .in_valid           (in_valid),
        .instruction        (instruction),
        .pc                 (pc),
        .rob_tag            (rob_tag),
        .exception_vector   (exception_vector),
        .wb                 (wb),
        .idex_rd            (idex.rd),
        .idex_mem_read      (idex.ctrl.mem_read),
        .next_idex          (next_idex),
        .pc_write_disable   (pc_write_disable),
        .ifid_write_disable (ifid_write_disable)
    );

    // ID/EX register, flush wins over the incoming payload
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idex <= '0;
        end else if (flush) begin
            idex <= '0;
        end else begin
            idex <= next_idex;
        end
    end

    no_alloc_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !idex.valid |-> !idex.allocate)
        else $error("decode_top: ROB allocate raised on an invalid ID/EX entry");

endmodule

/* tb/tb_decode.sv */
`timescale 1ns/1ns

module tb_decode;

    localparam int num_instr = 2000;
    // Every instruction may stall once, plus idle slots and reset
    localparam int max_cycles = 2 * num_instr + 500;

    logic                clk;
    logic                arst_n;
    logic                in_valid;
    logic [31:0]         instruction;
    logic [31:0]         pc;
    pipe_pkg::rob_tag_t  rob_tag;
    pipe_pkg::exc_vec_t  exception_vector;
    pipe_pkg::wb_port_t  wb;
    logic                flush;
    pipe_pkg::idex_t     idex;
    logic                pc_write_disable;
    logic                ifid_write_disable;

    logic [31:0]         lcg_state;
    logic [31:0]         model_regs [0:31];
    pipe_pkg::idex_t     model_idex;
    pipe_pkg::idex_t     expected;
    isa_pkg::decoded_t   dec;
    logic                exp_stall;
    logic                hold;
    logic                last_was_load;
    isa_pkg::reg_idx_t   last_load_rd;
    logic [31:0]         new_instr;
    logic [31:0]         next_pc;
    int                  issued;
    int                  step;
    int                  idex_errors;
    int                  stall_errors;
    int                  stall_count;
    int                  cycle_count;

    decode_top DUT (
        .clk                (clk),
        .arst_n             (arst_n),
        .in_valid           (in_valid),
        .instruction        (instruction),
        .pc                 (pc),
        .rob_tag            (rob_tag),
        .exception_vector   (exception_vector),
        .wb                 (wb),
        .flush              (flush),
        .idex               (idex),
        .pc_write_disable   (pc_write_disable),
        .ifid_write_disable (ifid_write_disable)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:8]) % n;
    endfunction

    function automatic logic is_legal_opcode(input logic [6:0] opc);
        return opc inside {isa_pkg::opc_lui, isa_pkg::opc_auipc, isa_pkg::opc_jal,
                           isa_pkg::opc_jalr, isa_pkg::opc_branch, isa_pkg::opc_load,
                           isa_pkg::opc_store, isa_pkg::opc_op_imm, isa_pkg::opc_op};
    endfunction

    // Reference decoder built from the RV32I format tables
    function automatic isa_pkg::decoded_t ref_decode(input logic [31:0] instr);
        isa_pkg::decoded_t  d;
        logic signed [31:0] s;
        logic [31:0]        hi;
        logic [6:0]         opc;
        s = instr;
        opc = instr[6:0];
        d = '0;
        d.opcode = isa_pkg::opcode_e'(opc);
        d.rd = instr[11:7];
        d.funct3 = instr[14:12];
        d.rs1 = instr[19:15];
        d.rs2 = instr[24:20];
        d.funct7 = instr[31:25];
        d.instr_type = isa_pkg::itype_no_wb;
        if (opc == isa_pkg::opc_lui || opc == isa_pkg::opc_auipc) begin
            d.instr_type = isa_pkg::itype_u;
            d.imm = instr & 32'hffff_f000;
        end else if (opc == isa_pkg::opc_jal) begin
            hi = s >>> 31;
            d.instr_type = isa_pkg::itype_j;
            d.imm = (hi << 20) | {12'b0, instr[19:12], 12'b0} | {20'b0, instr[20], 11'b0}
                    | {21'b0, instr[30:21], 1'b0};
        end else if (opc inside {isa_pkg::opc_jalr, isa_pkg::opc_load, isa_pkg::opc_op_imm}) begin
            d.instr_type = isa_pkg::itype_i;
            d.imm = s >>> 20;
            d.uses_rs1 = 1'b1;
        end else if (opc == isa_pkg::opc_store) begin
            hi = s >>> 25;
            d.imm = (hi << 5) | {27'b0, instr[11:7]};
            d.uses_rs1 = 1'b1;
            d.uses_rs2 = 1'b1;
        end else if (opc == isa_pkg::opc_branch) begin
            hi = s >>> 31;
            d.imm = (hi << 12) | {20'b0, instr[7], 11'b0} | {21'b0, instr[30:25], 5'b0}
                    | {27'b0, instr[11:8], 1'b0};
            d.uses_rs1 = 1'b1;
            d.uses_rs2 = 1'b1;
        end else if (opc == isa_pkg::opc_op) begin
            d.instr_type = isa_pkg::itype_r;
            d.uses_rs1 = 1'b1;
            d.uses_rs2 = 1'b1;
        end
        return d;
    endfunction

    // Field order: alu_src, alu_op, mem_write, mem_read, branch_inst, mem_to_reg, reg_write
    function automatic pipe_pkg::ctrl_t ref_ctrl(input logic [6:0] opc);
        pipe_pkg::ctrl_t c;
        c = '0;
        case (opc)
            isa_pkg::opc_load:   c = '{1'b1, isa_pkg::alu_add, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
            isa_pkg::opc_store:  c = '{1'b1, isa_pkg::alu_add, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
            isa_pkg::opc_branch: c = '{1'b0, isa_pkg::alu_sub_cmp, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
            isa_pkg::opc_op:     c = '{1'b0, isa_pkg::alu_r_funct, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
            isa_pkg::opc_op_imm: c = '{1'b1, isa_pkg::alu_i_funct, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
            isa_pkg::opc_lui:    c = '{1'b0, isa_pkg::alu_pass_imm, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
            isa_pkg::opc_auipc,
            isa_pkg::opc_jal:    c = '{1'b0, isa_pkg::alu_pc_add, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
            isa_pkg::opc_jalr:   c = '{1'b0, isa_pkg::alu_add, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
            default:             c = '0;
        endcase
        return c;
    endfunction

    // Register model seen through the same-cycle writeback
    function automatic logic [31:0] read_model(input isa_pkg::reg_idx_t idx);
        if (idx == 5'd0)
            return 32'd0;
        if (wb.write_enable && wb.write_reg == idx)
            return wb.write_data;
        return model_regs[idx];
    endfunction

    task automatic make_instruction(output logic [31:0] instr);
        logic [6:0] opc;
        instr = lcg_next();
        opc = instr[6:0];
        case (rand_below(20))
            0: begin
                while (is_legal_opcode(opc)) begin
                    opc = opc + 7'd1;
                end
            end
            1, 2, 3, 4: opc = isa_pkg::opc_load;
            5, 6:       opc = isa_pkg::opc_store;
            7, 8:       opc = isa_pkg::opc_branch;
            9, 10, 11:  opc = isa_pkg::opc_op;
            12, 13, 14: opc = isa_pkg::opc_op_imm;
            15:         opc = isa_pkg::opc_lui;
            16:         opc = isa_pkg::opc_auipc;
            17:         opc = isa_pkg::opc_jal;
            default:    opc = isa_pkg::opc_jalr;
        endcase
        instr[6:0] = opc;
        // Lean on the last load so that load-use pairs come up often
        if (last_was_load && rand_below(100) < 60) begin
            instr[19:15] = last_load_rd;
            if (rand_below(2) == 1)
                instr[24:20] = last_load_rd;
        end
        last_was_load = (opc == isa_pkg::opc_load);
        last_load_rd = instr[11:7];
    endtask

    task automatic check_idex(input string name, input pipe_pkg::idex_t exp_val,
                              input pipe_pkg::idex_t act_val);
        if (act_val !== exp_val) begin
            idex_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic check_stall(input string name, input logic [1:0] exp_val,
                               input logic [1:0] act_val);
        if (act_val !== exp_val) begin
            stall_errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp_val, act_val);
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: no end of test after %0d cycles, idex errors %0d, stall errors %0d",
                     cycle_count, idex_errors, stall_errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        lcg_state = 32'd27;
        clk = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        instruction = '0;
        pc = '0;
        rob_tag = '0;
        exception_vector = '0;
        wb = '0;
        flush = 1'b0;
        model_idex = '0;
        hold = 1'b0;
        last_was_load = 1'b0;
        last_load_rd = '0;
        next_pc = 32'h0000_1000;
        issued = 0;
        step = 0;
        idex_errors = 0;
        stall_errors = 0;
        stall_count = 0;
        cycle_count = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        while (issued < num_instr) begin
            @(negedge clk);
            check_idex($sformatf("idex step %0d", step), model_idex, idex);
            step++;
            // A held fetch re-presents the same instruction
            if (!hold) begin
                if (rand_below(100) < 5) begin
                    in_valid = 1'b0;
                end else begin
                    make_instruction(new_instr);
                    in_valid = 1'b1;
                    instruction = new_instr;
                    pc = next_pc;
                    next_pc = next_pc + 32'd4;
                    rob_tag = rob_tag + 1'b1;
                    exception_vector = pipe_pkg::exc_vec_t'(rand_below(8));
                    issued++;
                end
            end
            wb.write_enable = (rand_below(100) < 30);
            wb.write_reg = (rand_below(3) == 0) ? instruction[19:15]
                                                : isa_pkg::reg_idx_t'(rand_below(32));
            wb.write_data = lcg_next();
            flush = (rand_below(100) < 2);

            dec = ref_decode(instruction);
            exp_stall = in_valid && model_idex.ctrl.mem_read && (model_idex.rd != 5'd0) &&
                        ((dec.uses_rs1 && dec.rs1 == model_idex.rd) ||
                         (dec.uses_rs2 && dec.rs2 == model_idex.rd));
            expected = '0;
            expected.valid = in_valid && !exp_stall;
            expected.ctrl = expected.valid ? ref_ctrl(instruction[6:0]) : '0;
            expected.pc = pc;
            expected.instruction = instruction;
            expected.data_a = read_model(dec.rs1);
            expected.data_b = read_model(dec.rs2);
            expected.imm = dec.imm;
            expected.rd = dec.rd;
            expected.rs1 = dec.rs1;
            expected.rs2 = dec.rs2;
            expected.funct3 = dec.funct3;
            expected.funct7 = dec.funct7;
            expected.rob_tag = rob_tag;
            expected.allocate = expected.valid && (dec.instr_type != isa_pkg::itype_no_wb ||
                                                   instruction[6:0] == isa_pkg::opc_store);
            expected.exception_vector = exception_vector;

            #10;
            check_stall($sformatf("stall step %0d", step), {exp_stall, exp_stall},
                        {pc_write_disable, ifid_write_disable});
            hold = ifid_write_disable;
            if (exp_stall)
                stall_count++;

            // State the DUT takes on at the coming rising edge
            if (wb.write_enable && wb.write_reg != 5'd0)
                model_regs[wb.write_reg] = wb.write_data;
            model_idex = flush ? '0 : expected;
        end

        @(negedge clk);
        check_idex($sformatf("idex step %0d", step), model_idex, idex);

        $display("Errors: idex %0d, stall %0d (stalls seen %0d)",
                 idex_errors, stall_errors, stall_count);
        if (idex_errors + stall_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* decode_subsys.f */
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/control_unit.sv
verilog/hazard_unit.sv
verilog/stage_decode.sv
verilog/decode_top.sv
tb/tb_decode.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the decode subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_decode -f decode_subsys.f \
    -Mdir obj_dir -o tb_decode_sim

output=$(./obj_dir/tb_decode_sim)
echo "$output"

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi
